// ==== Bender.yml ====
package:
  name: single_cpu

sources:
  - include_dirs:
      - include
    files:
      - hw/rvPkg.sv
      - hw/fetchUnit.sv
      - hw/decodeControl.sv
      - hw/registerFile.sv
      - hw/aluExec.sv
      - hw/dataMem.sv
      - hw/singleCpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/cpuChecker.sv
      - dv/cpuAssert.sv
      - dv/tbSingleCpu.sv

// ==== dv/cpuAssert.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_defs.svh"

module cpuAssert (
    input logic                  CLK,
    input logic                  rstN,
    input logic [`RV_XLEN-1:0]   instr,
    input logic [`RV_REG_AW-1:0] rs1,
    input logic [`RV_REG_AW-1:0] rs2,
    input logic [`RV_XLEN-1:0]   rd1,
    input logic [`RV_XLEN-1:0]   rd2,
    input rvPkg::retireS         retire
);

    int failCount = 0; // Tally of failed properties

    // pc is held at zero through reset, so the first retirement is at 0
    resetPc: assert property (@(posedge CLK) !rstN |=> (retire.pc == '0))
        else begin
            failCount++;
            $error("pc was not held at zero during reset");
        end

    pcAligned: assert property (@(posedge CLK) disable iff (!rstN) retire.pc[1:0] == 2'b00)
        else begin
            failCount++;
            $error("Retired pc is not word aligned");
        end

    // Writes aimed at x0 are dropped, so both read ports see zero for x0
    x0ReadsZero: assert property (@(posedge CLK) disable iff (!rstN)
        ((rs1 != '0) || (rd1 == '0)) && ((rs2 != '0) || (rd2 == '0)))
        else begin
            failCount++;
            $error("Register x0 did not read as zero");
        end

    pcStep: assert property (@(posedge CLK) disable iff (!rstN)
        (instr[6:0] != `RV_OP_BRANCH) |=> (retire.pc == $past(retire.pc) + 32'd4))
        else begin
            failCount++;
            $error("pc did not advance by 4 after a non-branch instruction");
        end

endmodule

bind singleCpu cpuAssert assertInst (
    .CLK(CLK),
    .rstN(rstN),
    .instr(instr),
    .rs1(rs1),
    .rs2(rs2),
    .rd1(rd1),
    .rd2(rd2),
    .retire(retire)
);

`default_nettype wire

// ==== dv/cpuChecker.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_defs.svh"

module cpuChecker (
    input logic                   CLK,
    input logic                   rstN,
    input logic                   progWe,
    input logic [`RV_IMEM_AW-1:0] progAddr,
    input logic [`RV_XLEN-1:0]    progData,
    input logic [`RV_XLEN-1:0]    instr,
    input rvPkg::retireS          retire
);

    int checkCount = 0;
    int errorCount = 0;
    int testChecks [6] = '{default: 0};
    int testErrors [6] = '{default: 0};
    string testNames [6] = '{"aluOps", "addiImm", "loadStore", "beq", "x0Writes", "reset"};

    logic [`RV_XLEN-1:0] prog [`RV_IMEM_WORDS]; // Copy seen on the program port
    logic [`RV_XLEN-1:0] regs [32];
    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
    logic [`RV_XLEN-1:0] pc;
    int pcCat; // Category of the instruction that chose the current pc

    task automatic checkField(input int cat, input string name,
                              input logic [31:0] expVal, input logic [31:0] actVal);
        testChecks[cat]++;
        checkCount++;
        if (actVal !== expVal) begin
            testErrors[cat]++;
            errorCount++;
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h",
                     $time, name, expVal, actVal);
        end
    endtask

    task automatic clearModel();
        pc = '0;
        pcCat = 5;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < `RV_DMEM_WORDS; i++) dmem[i] = '0;
    endtask

    task automatic stepModel();
        rvPkg::instrU ins;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic wr;
        logic st;
        int cat;
        ins.word = (pc[31:8] != '0) ? `RV_NOP : prog[pc[`RV_IMEM_AW+1:2]];
        w = ins.word;
        a = regs[ins.rFmt.rs1];
        b = regs[ins.rFmt.rs2];
        wr = 1'b0;
        st = 1'b0;
        res = '0;
        addr = '0;
        nextPc = pc + 32'd4;
        cat = 1;
        case (ins.rFmt.opcode)
            `RV_OP_R: begin
                cat = 0;
                wr = 1'b1;
                case ({ins.rFmt.funct7, ins.rFmt.funct3})
                    {7'h00, 3'd0}: res = a + b;
                    {7'h20, 3'd0}: res = a - b;
                    {7'h00, 3'd7}: res = a & b;
                    {7'h00, 3'd6}: res = a | b;
                    {7'h00, 3'd2}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            `RV_OP_I: begin
                wr = (ins.iFmt.funct3 == 3'd0);
                res = a + {{20{w[31]}}, w[31:20]};
            end
            `RV_OP_LOAD: begin
                cat = 2;
                wr = (ins.iFmt.funct3 == 3'd2);
                addr = a + {{20{w[31]}}, w[31:20]};
                res = dmem[addr[`RV_DMEM_AW+1:2]];
            end
            `RV_OP_STORE: begin
                cat = 2;
                st = (ins.sFmt.funct3 == 3'd2);
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
            end
            `RV_OP_BRANCH: begin
                cat = 3;
                if (ins.bFmt.funct3 == 3'd0 && a == b)
                    nextPc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            default: cat = 1;
        endcase
        if (wr && ins.rFmt.rd == 5'd0) cat = 4; // Write aimed at x0 retires as a no-op
        wr = wr && (ins.rFmt.rd != 5'd0);
        checkField(pcCat, "retire.pc", pc, retire.pc);
        checkField(cat, "instr", ins.word, instr);
        checkField(cat, "retire.regWe", wr, retire.regWe);
        if (wr) begin
            checkField(cat, "retire.rd", ins.rFmt.rd, retire.rd);
            checkField(cat, "retire.regData", res, retire.regData);
        end
        checkField(cat, "retire.memWe", st, retire.memWe);
        if (st) begin
            checkField(cat, "retire.memAddr", addr, retire.memAddr);
            checkField(cat, "retire.memData", b, retire.memData);
        end
        if (wr) regs[ins.rFmt.rd] = res;
        if (st) dmem[addr[`RV_DMEM_AW+1:2]] = b;
        pc = nextPc;
        pcCat = cat;
    endtask

    task automatic printTests();
        for (int i = 0; i < 6; i++) begin
            $display("Test %-10s %0d checks, %0d errors", testNames[i],
                     testChecks[i], testErrors[i]);
        end
    endtask

    always @(posedge CLK) begin
        if (progWe && !rstN) prog[progAddr] <= progData;
    end

    // Sample mid-cycle where the retire struct is settled
    always @(negedge CLK) begin
        if (!rstN) begin
            checkField(5, "retire.regWe", 1'b0, retire.regWe);
            checkField(5, "retire.memWe", 1'b0, retire.memWe);
            clearModel();
        end else begin
            stepModel();
        end
    end

endmodule

`default_nettype wire

// ==== dv/tbSingleCpu.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_defs.svh"

module tbSingleCpu;

    localparam int clkPeriod = 100;
    localparam int resetCycles = 8;
    localparam int runCycles = 200;
    localparam int loadCycles = `RV_IMEM_WORDS + 1;
    localparam int limitCycles = loadCycles + resetCycles + runCycles + 20;

    // R-type funct7 and funct3 for add, sub, and, or, slt
    localparam logic [6:0] rF7 [5] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00};
    localparam logic [2:0] rF3 [5] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd2};

    logic CLK;
    logic rstN;
    logic progWe;
    logic [`RV_IMEM_AW-1:0] progAddr;
    logic [`RV_XLEN-1:0] progData;
    logic [`RV_XLEN-1:0] instr;
    rvPkg::retireS retire;

    logic [`RV_XLEN-1:0] prog [`RV_IMEM_WORDS];
    int unsigned seedDummy;
    int totalErrors;

    singleCpu singleCpu_inst (
        .CLK(CLK), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .instr(instr), .retire(retire)
    );

    cpuChecker cpuCheckerInst (
        .CLK(CLK), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .instr(instr), .retire(retire)
    );

    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] rTypeWord(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_R};
    endfunction

    function automatic logic [31:0] iTypeWord(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                              logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] storeWord(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] branchWord(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    task automatic buildProgram();
        int kind;
        int pick;
        int span;
        logic [4:0] base;
        logic [11:0] off;
        prog[0] = iTypeWord(12'd512, 5'd0, 3'd0, 5'd8, `RV_OP_I); // Base regs x8, x9
        prog[1] = iTypeWord(12'hf00, 5'd0, 3'd0, 5'd9, `RV_OP_I);
        for (int i = 2; i < `RV_IMEM_WORDS; i++) begin
            kind = $urandom_range(9, 0);
            base = 5'd0;
            off = 12'(4 * $urandom_range(63, 0));
            if ($urandom_range(1, 0) == 1) begin
                base = 5'd8 + 5'($urandom_range(1, 0));
                off = 12'(4 * $urandom_range(31, 0) - 64); // Negative offsets too
            end
            case (kind)
                0, 1, 2, 3: begin
                    pick = $urandom_range(4, 0);
                    prog[i] = rTypeWord(rF7[pick], 5'($urandom_range(9, 0)),
                                        5'($urandom_range(9, 0)), rF3[pick],
                                        5'($urandom_range(7, 0)));
                end
                4, 5: prog[i] = iTypeWord(12'($urandom), 5'($urandom_range(7, 0)), 3'd0,
                                          5'($urandom_range(7, 0)), `RV_OP_I);
                6, 9: prog[i] = iTypeWord(off, base, 3'd2, 5'($urandom_range(7, 0)),
                                          `RV_OP_LOAD);
                7: prog[i] = storeWord(off, 5'($urandom_range(7, 0)), base);
                default: begin
                    // Forward only, landing inside the array or just past it
                    span = (`RV_IMEM_WORDS - i < 4) ? `RV_IMEM_WORDS - i : 4;
                    prog[i] = branchWord(13'(4 * $urandom_range(span, 1)),
                                         5'($urandom_range(3, 0)), 5'($urandom_range(3, 0)));
                end
            endcase
        end
    endtask

    initial begin
        rstN = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        seedDummy = $urandom(32'hbd416d75);
        buildProgram();
        for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
            @(posedge CLK);
            #5;
            progWe = 1'b1;
            progAddr = `RV_IMEM_AW'(i);
            progData = prog[i];
        end
        @(posedge CLK);
        #5;
        progWe = 1'b0;
        repeat (resetCycles) @(posedge CLK); // Core stays in reset after the load
        #5;
        rstN = 1'b1;
        repeat (runCycles) @(posedge CLK);
        #5;
        cpuCheckerInst.printTests();
        totalErrors = cpuCheckerInst.errorCount + singleCpu_inst.assertInst.failCount;
        $display("Summary: %0d checks, %0d checker errors, %0d assertion failures",
                 cpuCheckerInst.checkCount, cpuCheckerInst.errorCount,
                 singleCpu_inst.assertInst.failCount);
        if (totalErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(limitCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", limitCycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/aluExec.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_defs.svh"

module aluExec (
    input  rvPkg::ctrlS         ctrl,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rd1,
    input  logic [`RV_XLEN-1:0] rd2,
    input  logic [`RV_XLEN-1:0] imm,
    output logic [`RV_XLEN-1:0] aluResult,
    output logic                branchTaken,
    output logic [`RV_XLEN-1:0] branchTarget
);

    logic [`RV_XLEN-1:0] opB;
    logic zero;

    assign opB = ctrl.aluSrc ? imm : rd2;

    always_comb begin
        case (ctrl.aluOp)
            rvPkg::aluAdd: aluResult = rd1 + opB;
            rvPkg::aluSub: aluResult = rd1 - opB;
            rvPkg::aluAnd: aluResult = rd1 & opB;
            rvPkg::aluOr:  aluResult = rd1 | opB;
            rvPkg::aluSlt: begin
                // Signed compare
                aluResult = {{(`RV_XLEN-1){1'b0}}, ($signed(rd1) < $signed(opB))};
            end
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // beq uses the subtract result
    assign branchTaken  = ctrl.branch & zero;
    assign branchTarget = pc + imm;

endmodule

`default_nettype wire

// ==== hw/dataMem.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_defs.svh"

module dataMem (
    input  logic                CLK,
    input  logic                rstN,
    input  rvPkg::ctrlS         ctrl,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic [`RV_XLEN-1:0] storeData,
    output logic [`RV_XLEN-1:0] wbData
);

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
    logic [`RV_DMEM_AW-1:0] wordIdx;

    // Byte offset ignored, upper bits alias
    assign wordIdx = addr[`RV_DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ctrl.memWrite) begin
            dmem[wordIdx] <= storeData;
        end
    end

    // Loaded word or ALU result back to the register file
    assign wbData = ctrl.memToReg ? dmem[wordIdx] : addr;

endmodule

`default_nettype wire

// ==== hw/decodeControl.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_defs.svh"

module decodeControl (
    input  rvPkg::instrU          instr,
    output rvPkg::ctrlS           ctrl,
    output logic [`RV_XLEN-1:0]   imm,
    output logic [`RV_REG_AW-1:0] rs1,
    output logic [`RV_REG_AW-1:0] rs2,
    output logic [`RV_REG_AW-1:0] rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [3:0] aluCtrlIn; // funct7 bit 5 over funct3
    rvPkg::aluOpE rOp;
    logic rKnown;

    assign opcode    = instr.rFmt.opcode;
    assign funct3    = instr.rFmt.funct3;
    assign aluCtrlIn = {instr.rFmt.funct7[5], funct3};

    assign rs1 = instr.rFmt.rs1;
    assign rs2 = instr.rFmt.rs2;
    assign rd  = instr.rFmt.rd;

    // ALU control for R-type
    always_comb begin
        rKnown = 1'b1;
        case (aluCtrlIn)
            4'b0000: rOp = rvPkg::aluAdd;
            4'b1000: rOp = rvPkg::aluSub;
            4'b0111: rOp = rvPkg::aluAnd;
            4'b0110: rOp = rvPkg::aluOr;
            4'b0010: rOp = rvPkg::aluSlt;
            default: begin
                rOp    = rvPkg::aluAdd;
                rKnown = 1'b0; // Outside the subset, retire as a no-op
            end
        endcase
    end

    // Main control, all zero for anything unsupported
    always_comb begin
        ctrl = '0;
        case (opcode)
            `RV_OP_R: begin
                ctrl.regWrite = rKnown;
                ctrl.aluOp    = rOp;
            end
            `RV_OP_I: begin
                ctrl.regWrite = (funct3 == 3'b000); // addi only
                ctrl.aluSrc   = 1'b1;
            end
            `RV_OP_LOAD: begin
                ctrl.regWrite = (funct3 == 3'b010); // lw only
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            `RV_OP_STORE: begin
                ctrl.memWrite = (funct3 == 3'b010); // sw only
                ctrl.aluSrc   = 1'b1;
            end
            `RV_OP_BRANCH: begin
                ctrl.branch = (funct3 == 3'b000); // beq only
                ctrl.aluOp  = rvPkg::aluSub;
            end
            default: ctrl = '0;
        endcase
    end

    // Immediate, sign extended from the view that matches the opcode
    always_comb begin
        case (opcode)
            `RV_OP_I, `RV_OP_LOAD:
                imm = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};
            `RV_OP_STORE:
                imm = {{20{instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
            `RV_OP_BRANCH:
                imm = {{20{instr.bFmt.bit12}}, instr.bFmt.bit11,
                       instr.bFmt.bits10to5, instr.bFmt.bits4to1, 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/fetchUnit.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_defs.svh"

module fetchUnit (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   progWe,
    input  logic [`RV_IMEM_AW-1:0] progAddr,
    input  logic [`RV_XLEN-1:0]    progData,
    input  logic                   branchTaken,
    input  logic [`RV_XLEN-1:0]    branchTarget,
    output logic [`RV_XLEN-1:0]    pc,
    output rvPkg::instrU           instr
);

    logic [`RV_XLEN-1:0] imem [`RV_IMEM_WORDS];
    logic [`RV_XLEN-1:0] nextPc;
    logic [`RV_IMEM_AW-1:0] wordIdx;
    logic outOfRange;

    assign wordIdx = pc[`RV_IMEM_AW+1:2]; // Byte address to word index

    // Anything past the array fetches a NOP
    assign outOfRange = (pc[`RV_XLEN-1:`RV_IMEM_AW+2] != '0);

    assign instr = outOfRange ? `RV_NOP : imem[wordIdx];

    assign nextPc = branchTaken ? branchTarget : pc + `RV_XLEN'd4;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // Program load port, only open while the core is held in reset
    always_ff @(posedge CLK) begin
        if (progWe && !rstN) begin
            imem[progAddr] <= progData;
        end
    end

endmodule

`default_nettype wire

// ==== hw/registerFile.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_defs.svh"

module registerFile (
    input  logic                  CLK,
    input  logic                  rstN,
    input  logic [`RV_REG_AW-1:0] rs1,
    input  logic [`RV_REG_AW-1:0] rs2,
    input  logic [`RV_REG_AW-1:0] rd,
    input  logic                  we,
    input  logic [`RV_XLEN-1:0]   wd,
    output logic [`RV_XLEN-1:0]   rd1,
    output logic [`RV_XLEN-1:0]   rd2
);

    logic [`RV_XLEN-1:0] regs [2**`RV_REG_AW];

    // Both read ports are combinational
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < 2**`RV_REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin // x0 stays zero
            regs[rd] <= wd;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rvPkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rvPkg;

    // One instruction word, seen through each encoding format
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rFmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iFmt;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sFmt;
        struct packed {
            logic       bit12;
            logic [5:0] bits10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] bits4to1;
            logic       bit11;
            logic [6:0] opcode;
        } bFmt;
    } instrU;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;   // Second operand from immediate
        logic  memWrite;
        logic  memToReg; // Write back the loaded word
        logic  branch;
        aluOpE aluOp;
    } ctrlS;

    // What one instruction did, reported once per cycle
    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic                  regWe;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   regData;
        logic                  memWe;
        logic [`RV_XLEN-1:0]   memAddr;
        logic [`RV_XLEN-1:0]   memData;
    } retireS;

endpackage

`default_nettype wire

// ==== hw/singleCpu.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "rv_defs.svh"

module singleCpu (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   progWe,
    input  logic [`RV_IMEM_AW-1:0] progAddr,
    input  logic [`RV_XLEN-1:0]    progData,
    output logic [`RV_XLEN-1:0]    instr,
    output rvPkg::retireS          retire
);

    logic [`RV_XLEN-1:0] pc;
    rvPkg::instrU fetched;
    rvPkg::ctrlS ctrl;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0] rd1;
    logic [`RV_XLEN-1:0] rd2;
    logic [`RV_XLEN-1:0] aluResult;
    logic branchTaken;
    logic [`RV_XLEN-1:0] branchTarget;
    logic [`RV_XLEN-1:0] wbData;

    assign instr = fetched; // Raw fetched word

    fetchUnit uFetch (
        .CLK(CLK), .rstN(rstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .pc(pc), .instr(fetched)
    );

    decodeControl uDecode (
        .instr(fetched), .ctrl(ctrl), .imm(imm),
        .rs1(rs1), .rs2(rs2), .rd(rd)
    );

    registerFile uRegs (
        .CLK(CLK), .rstN(rstN),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(ctrl.regWrite), .wd(wbData),
        .rd1(rd1), .rd2(rd2)
    );

    aluExec uAlu (
        .ctrl(ctrl), .pc(pc), .rd1(rd1), .rd2(rd2), .imm(imm),
        .aluResult(aluResult), .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    dataMem uDmem (
        .CLK(CLK), .rstN(rstN), .ctrl(ctrl),
        .addr(aluResult), .storeData(rd2), .wbData(wbData)
    );

    // Retirement report, strobes quiet in reset and for writes to x0
    always_comb begin
        retire.pc      = pc;
        retire.regWe   = rstN & ctrl.regWrite & (rd != '0);
        retire.rd      = rd;
        retire.regData = wbData;
        retire.memWe   = rstN & ctrl.memWrite;
        retire.memAddr = aluResult;
        retire.memData = rd2;
    end

endmodule

`default_nettype wire

// ==== include/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath width
`define RV_XLEN 32

// Register file addressing
`define RV_REG_AW 5

// Memory depths in words, with matching index widths
`define RV_IMEM_WORDS 64
`define RV_IMEM_AW 6
`define RV_DMEM_WORDS 64
`define RV_DMEM_AW 6

// Major opcodes of the supported subset
`define RV_OP_R      7'b0110011 // add sub and or slt
`define RV_OP_I      7'b0010011 // addi
`define RV_OP_LOAD   7'b0000011 // lw
`define RV_OP_STORE  7'b0100011 // sw
`define RV_OP_BRANCH 7'b1100011 // beq

// addi x0, x0, 0
`define RV_NOP 32'h00000013

`endif

// ==== list.f ====
+incdir+include
hw/rvPkg.sv
hw/fetchUnit.sv
hw/decodeControl.sv
hw/registerFile.sv
hw/aluExec.sv
hw/dataMem.sv
hw/singleCpu.sv
dv/cpuChecker.sv
dv/cpuAssert.sv
dv/tbSingleCpu.sv
